/* design/div_pkg.sv */
// Divider package
// Holds the operation encoding of the M-extension divide group,
// the default operand width and small helpers that decode an operation
`default_nettype none

package div_pkg;

	// Encoding follows the core's decoder for the funct3 divide group
	typedef enum logic [1:0] {
		DIV  = 2'd0,
		DIVU = 2'd1,
		REM  = 2'd2,
		REMU = 2'd3
	} div_op_e;

	// Default operand width for an RV32 core
	parameter int DIV_XLEN = 32;

	// True for the operations that treat both operands as two's complement
	function automatic logic op_is_signed(div_op_e op);
		return (op == DIV) || (op == REM);
	endfunction

	// True for the operations that return the remainder instead of the quotient
	function automatic logic op_is_rem(div_op_e op);
		return (op == REM) || (op == REMU);
	endfunction

endpackage

`default_nettype wire

/* design/div_ctrl_fsm.sv */
// Divider control FSM
// Qualifies requests with the load hazard, raises div_running in the
// accepting cycle and walks the datapath through one divide
`default_nettype none

module div_ctrl_fsm (
	input  logic CLK,
	input  logic nrst,
	input  logic div_valid,
	input  logic load_hazard,
	input  logic last_step,
	output logic accept,
	output logic step_en,
	output logic finish,
	output logic div_running
);

	// RESET holds for one cycle after nrst is released
	// IDLE waits for a qualified request
	// DIVIDE produces one quotient bit per cycle
	// DONE is the single cycle where div_out is fresh and the pipeline runs again
	typedef enum logic [1:0] {
		ST_RESET  = 2'd0,
		ST_IDLE   = 2'd1,
		ST_DIVIDE = 2'd2,
		ST_DONE   = 2'd3
	} state_e;

	state_e state;
	state_e state_next;

	// A request only counts while idle and with no load hazard pending
	assign accept = (state == ST_IDLE) && div_valid && !load_hazard;

	// Every DIVIDE cycle is a shift-subtract step
	assign step_en = (state == ST_DIVIDE);

	// The counter flags the final step, so finish marks the edge into DONE
	assign finish = step_en && last_step;

	// The stall must start in the same cycle the request is seen
	// so running is raised combinationally from accept
	assign div_running = accept || (state == ST_DIVIDE);

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			state <= ST_RESET;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_RESET: begin
				state_next = ST_IDLE;
			end
			ST_IDLE: begin
				if (accept) begin
					state_next = ST_DIVIDE;
				end
			end
			ST_DIVIDE: begin
				// Leave after exactly XLEN steps
				if (last_step) begin
					state_next = ST_DONE;
				end
			end
			ST_DONE: begin
				state_next = ST_IDLE;
			end
			default: begin
				state_next = ST_RESET;
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/div_step_counter.sv */
// Divider step counter
// Counts shift-subtract steps of one operation and flags the final one
`default_nettype none

module div_step_counter #(
	parameter int XLEN = 32
) (
	input  logic CLK,
	input  logic nrst,
	input  logic clear,
	input  logic step_en,
	output logic last_step
);

	// One extra bit so the count can reach XLEN without wrapping
	localparam int CW = $clog2(XLEN) + 1;

	logic [CW-1:0] count;

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			count <= '0;
		end else if (clear) begin
			// A new operation starts from step zero
			count <= '0;
		end else if (step_en) begin
			count <= count + 1'b1;
		end
	end

	// The count holds the number of steps already taken
	// so step XLEN is the one seen while it reads XLEN-1
	assign last_step = step_en && (count == CW'(XLEN - 1));

endmodule

`default_nettype wire

/* design/div_datapath.sv */
// Divider datapath
// Captures the operands as magnitudes with their sign handling and runs
// a restoring shift-subtract divide, one quotient bit per step
`default_nettype none

module div_datapath #(
	parameter int XLEN = 32
) (
	input  logic             CLK,
	input  logic             nrst,
	input  logic             load,
	input  logic             step_en,
	input  div_pkg::div_op_e op,
	input  logic [XLEN-1:0]  op_a,
	input  logic [XLEN-1:0]  op_b,
	output logic [XLEN-1:0]  quotient,
	output logic [XLEN-1:0]  remainder,
	output logic             neg_quot,
	output logic             neg_rem,
	output logic             div_zero,
	output logic             overflow,
	output logic [XLEN-1:0]  op_a_held
);
	import div_pkg::*;

	localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN - 1){1'b0}}};

	logic            is_signed;
	logic            sign_a;
	logic            sign_b;
	logic [XLEN-1:0] mag_a;
	logic [XLEN-1:0] mag_b;
	logic [XLEN-1:0] rem_q;
	logic [XLEN-1:0] quo_q;
	logic [XLEN-1:0] dvs_q;
	logic [XLEN:0]   trial;
	logic [XLEN:0]   diff;
	logic [XLEN-1:0] rem_next;
	logic [XLEN-1:0] quo_next;

	// Sign bits only matter for DIV and REM
	assign is_signed = op_is_signed(op);
	assign sign_a    = is_signed && op_a[XLEN-1];
	assign sign_b    = is_signed && op_b[XLEN-1];

	// Magnitudes of the operands
	// The most negative value maps onto itself, which is right as an unsigned magnitude
	assign mag_a = sign_a ? -op_a : op_a;
	assign mag_b = sign_b ? -op_b : op_b;

	// Bring down the next dividend bit from the top of the quotient register
	assign trial = {rem_q, quo_q[XLEN-1]};
	assign diff  = trial - {1'b0, dvs_q};

	// A clear top bit of diff means the divisor fit, so keep the difference
	always_comb begin
		if (!diff[XLEN]) begin
			rem_next = diff[XLEN-1:0];
			quo_next = {quo_q[XLEN-2:0], 1'b1};
		end else begin
			rem_next = trial[XLEN-1:0];
			quo_next = {quo_q[XLEN-2:0], 1'b0};
		end
	end

	// Dividend bits shift out of quo_q while quotient bits shift in
	// behind them, so after XLEN steps quo_q holds the whole quotient
	always_ff @(posedge CLK) begin
		if (load) begin
			rem_q     <= '0;
			quo_q     <= mag_a;
			dvs_q     <= mag_b;
			op_a_held <= op_a;
		end else if (step_en) begin
			rem_q <= rem_next;
			quo_q <= quo_next;
		end
	end

	// Sign and corner-case flags are decided from the raw operands at capture
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			neg_quot <= 1'b0;
			neg_rem  <= 1'b0;
			div_zero <= 1'b0;
			overflow <= 1'b0;
		end else if (load) begin
			// Quotient is negative when exactly one operand is
			neg_quot <= sign_a ^ sign_b;
			// Remainder takes the sign of the dividend
			neg_rem  <= sign_a;
			div_zero <= (op_b == '0);
			overflow <= is_signed && (op_a == MOST_NEG) && (op_b == '1);
		end
	end

	// The outputs show the values after the step of the current cycle
	// so in the last DIVIDE cycle they already carry the final result
	assign quotient  = quo_next;
	assign remainder = rem_next;

endmodule

`default_nettype wire

/* design/div_result_sel.sv */
// Divider result stage
// Picks quotient or remainder, restores the signs, applies the RISC-V
// divide-by-zero and overflow results and registers div_out
`default_nettype none

module div_result_sel #(
	parameter int XLEN = 32
) (
	input  logic             CLK,
	input  logic             nrst,
	input  logic             accept,
	input  logic             finish,
	input  div_pkg::div_op_e op,
	input  logic [XLEN-1:0]  quotient,
	input  logic [XLEN-1:0]  remainder,
	input  logic             neg_quot,
	input  logic             neg_rem,
	input  logic             div_zero,
	input  logic             overflow,
	input  logic [XLEN-1:0]  op_a_held,
	output logic [XLEN-1:0]  div_out
);
	import div_pkg::*;

	div_op_e         op_q;
	logic [XLEN-1:0] quot_fix;
	logic [XLEN-1:0] rem_fix;

	always_comb begin
		if (div_zero) begin
			// x / 0 gives all ones and x % 0 gives x
			quot_fix = '1;
			rem_fix  = op_a_held;
		end else if (overflow) begin
			// Most negative over minus one returns the dividend with no remainder
			quot_fix = op_a_held;
			rem_fix  = '0;
		end else begin
			quot_fix = neg_quot ? -quotient : quotient;
			rem_fix  = neg_rem ? -remainder : remainder;
		end
	end

	// The operation is latched at accept since the caller may change div_op afterwards
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			op_q    <= DIV;
			div_out <= '0;
		end else begin
			if (accept) begin
				op_q <= op;
			end
			// div_out holds until the next finish
			if (finish) begin
				div_out <= op_is_rem(op_q) ? rem_fix : quot_fix;
			end
		end
	end

endmodule

`default_nettype wire

/* design/divider_unit.sv */
// Radix-2 integer divider for the pipelined core
// Runs DIV, DIVU, REM and REMU in XLEN steps and stalls the pipeline
// through div_running while an operation is in flight
`default_nettype none

module divider_unit #(
	parameter int XLEN = div_pkg::DIV_XLEN
) (
	input  logic             CLK,
	input  logic             nrst,
	input  logic             load_hazard,
	input  logic             div_valid,
	input  div_pkg::div_op_e div_op,
	input  logic [XLEN-1:0]  op_a,
	input  logic [XLEN-1:0]  op_b,
	output logic             div_running,
	output logic [XLEN-1:0]  div_out
);

	logic            accept;
	logic            step_en;
	logic            finish;
	logic            last_step;
	logic [XLEN-1:0] quotient;
	logic [XLEN-1:0] remainder;
	logic            neg_quot;
	logic            neg_rem;
	logic            div_zero;
	logic            overflow;
	logic [XLEN-1:0] op_a_held;

	// Control decides when an operation starts, steps and ends
	div_ctrl_fsm ctrl0 (
		.CLK         (CLK),
		.nrst        (nrst),
		.div_valid   (div_valid),
		.load_hazard (load_hazard),
		.last_step   (last_step),
		.accept      (accept),
		.step_en     (step_en),
		.finish      (finish),
		.div_running (div_running)
	);

	// The same accept that loads the operands restarts the step count
	div_step_counter #(.XLEN(XLEN)) cnt0 (
		.CLK       (CLK),
		.nrst      (nrst),
		.clear     (accept),
		.step_en   (step_en),
		.last_step (last_step)
	);

	div_datapath #(.XLEN(XLEN)) dp0 (
		.CLK       (CLK),
		.nrst      (nrst),
		.load      (accept),
		.step_en   (step_en),
		.op        (div_op),
		.op_a      (op_a),
		.op_b      (op_b),
		.quotient  (quotient),
		.remainder (remainder),
		.neg_quot  (neg_quot),
		.neg_rem   (neg_rem),
		.div_zero  (div_zero),
		.overflow  (overflow),
		.op_a_held (op_a_held)
	);

	div_result_sel #(.XLEN(XLEN)) res0 (
		.CLK       (CLK),
		.nrst      (nrst),
		.accept    (accept),
		.finish    (finish),
		.op        (div_op),
		.quotient  (quotient),
		.remainder (remainder),
		.neg_quot  (neg_quot),
		.neg_rem   (neg_rem),
		.div_zero  (div_zero),
		.overflow  (overflow),
		.op_a_held (op_a_held),
		.div_out   (div_out)
	);

endmodule

`default_nettype wire

/* tb/tb_divider_unit.sv */
// Testbench for the radix-2 divider unit
// Drives directed, corner-case and LCG random operations, predicts div_out
// from the RISC-V M-extension rules and checks the stall timing of div_running
`default_nettype none

module tb_divider_unit;
	import div_pkg::*;

	localparam int XLEN       = DIV_XLEN;
	localparam int WAIT_LIMIT = 4 * XLEN + 20;

	logic            CLK;
	logic            nrst;
	logic            load_hazard;
	logic            div_valid;
	div_op_e         div_op;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic            div_running;
	logic [XLEN-1:0] div_out;

	// Expected results of accepted operations, oldest first
	logic [XLEN-1:0] expect_q[$];
	logic [XLEN-1:0] last_expected;
	logic [31:0]     lcg_state = 32'he2c7ca1b;
	int              issued;
	int              checked;

	divider_unit #(.XLEN(XLEN)) dut0 (
		.CLK         (CLK),
		.nrst        (nrst),
		.load_hazard (load_hazard),
		.div_valid   (div_valid),
		.div_op      (div_op),
		.op_a        (op_a),
		.op_b        (op_b),
		.div_running (div_running),
		.div_out     (div_out)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Numerical Recipes constants, full 32-bit state
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [XLEN-1:0] rand_word();
		logic [63:0] wide;
		wide = {lcg_next(), lcg_next()};
		return wide[XLEN-1:0];
	endfunction

	// SystemVerilog signed division truncates toward zero and the remainder
	// takes the dividend's sign, as RISC-V requires outside the corner cases
	// The signed divide sits inside $unsigned so the unsigned branches of
	// the conditional cannot turn it into an unsigned divide
	function automatic logic [XLEN-1:0] ref_div(div_op_e op, logic [XLEN-1:0] a,
			logic [XLEN-1:0] b);
		logic signed [XLEN-1:0] sa;
		logic signed [XLEN-1:0] sb;
		logic [XLEN-1:0]        most_neg;
		logic                   ovf;
		sa       = a;
		sb       = b;
		most_neg = {1'b1, {(XLEN - 1){1'b0}}};
		ovf      = (a == most_neg) && (b == '1);
		case (op)
			DIV:     return (b == '0) ? '1 : (ovf ? a : $unsigned(sa / sb));
			DIVU:    return (b == '0) ? '1 : a / b;
			REM:     return (b == '0) ? a : (ovf ? '0 : $unsigned(sa % sb));
			REMU:    return (b == '0) ? a : a % b;
			default: return '0;
		endcase
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_out(input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
		if (actual !== expected) begin
			report_failure($sformatf("ERROR div_out expected %h actual %h", expected, actual));
		end
	endtask

	task automatic check_running(input logic expected, input logic actual);
		if (actual !== expected) begin
			report_failure($sformatf("ERROR div_running expected %h actual %h", expected, actual));
		end
	endtask

	task automatic check_busy_cycles(input int expected, input int actual);
		if (actual != expected) begin
			report_failure($sformatf("ERROR div_running cycles expected %h actual %h",
				expected, actual));
		end
	endtask

	// Changes the operand inputs while an operation is in flight
	task automatic scramble_inputs();
		logic [31:0] r;
		r      = lcg_next();
		div_op = div_op_e'(r[31:30]);
		op_a   = rand_word();
		op_b   = rand_word();
	endtask

	// Issues one request and waits for div_running to fall
	// Ends at the falling edge of the DONE cycle
	task automatic run_op(input div_op_e op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b, input logic scramble);
		int waited;
		@(posedge CLK);
		#1;
		div_valid     = 1'b1;
		load_hazard   = 1'b0;
		div_op        = op;
		op_a          = a;
		op_b          = b;
		last_expected = ref_div(op, a, b);
		expect_q.push_back(last_expected);
		issued        = issued + 1;
		@(negedge CLK);
		// The stall has to show up in the accepting cycle itself
		check_running(1'b1, div_running);
		@(posedge CLK);
		#1;
		div_valid = 1'b0;
		if (scramble) begin
			scramble_inputs();
		end
		waited = 0;
		@(negedge CLK);
		while (div_running !== 1'b0) begin
			waited = waited + 1;
			if (waited > WAIT_LIMIT) begin
				report_failure("Timeout while waiting for div_running to fall");
			end
			@(posedge CLK);
			#1;
			if (scramble) begin
				scramble_inputs();
			end
			@(negedge CLK);
		end
	endtask

	// Compare process: measures each busy period and checks div_out in the
	// first cycle after it, against the oldest outstanding prediction
	initial begin : compare_proc
		int run_len;
		run_len = 0;
		forever begin
			@(negedge CLK);
			if (nrst !== 1'b1) begin
				run_len = 0;
			end else if (div_running === 1'b1) begin
				run_len = run_len + 1;
			end else if (run_len != 0) begin
				check_busy_cycles(XLEN + 1, run_len);
				if (expect_q.size() == 0) begin
					report_failure("div_running fell with no operation outstanding");
				end
				check_out(expect_q.pop_front(), div_out);
				checked = checked + 1;
				run_len = 0;
			end
		end
	end

	initial begin : stimulus_proc
		logic [31:0]     r;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] most_neg;
		most_neg    = {1'b1, {(XLEN - 1){1'b0}}};
		issued      = 0;
		checked     = 0;
		nrst        = 1'b0;
		load_hazard = 1'b0;
		div_valid   = 1'b0;
		div_op      = DIV;
		op_a        = '0;
		op_b        = '0;
		repeat (9) @(posedge CLK);
		@(negedge CLK);
		check_running(1'b0, div_running);
		check_out('0, div_out);

		// Release reset with a request that lands in the RESET cycle
		@(posedge CLK);
		#1;
		nrst      = 1'b1;
		div_valid = 1'b1;
		op_a      = XLEN'(100);
		op_b      = XLEN'(7);
		@(negedge CLK);
		check_running(1'b0, div_running);
		@(posedge CLK);
		#1;
		div_valid = 1'b0;
		@(negedge CLK);
		check_running(1'b0, div_running);
		check_out('0, div_out);

		// All sign combinations, with nonzero remainders
		for (int k = 0; k < 4; k++) begin
			run_op(div_op_e'(k), XLEN'(20), XLEN'(6), 1'b0);
			run_op(div_op_e'(k), XLEN'(-20), XLEN'(6), 1'b0);
			run_op(div_op_e'(k), XLEN'(20), XLEN'(-6), 1'b0);
			run_op(div_op_e'(k), XLEN'(-20), XLEN'(-6), 1'b0);
			run_op(div_op_e'(k), XLEN'(3), XLEN'(9), 1'b0);
			run_op(div_op_e'(k), '1, XLEN'(1), 1'b0);
			// Division by zero for every operation
			run_op(div_op_e'(k), XLEN'(-5), '0, 1'b0);
			run_op(div_op_e'(k), XLEN'(12345), '0, 1'b0);
			// Signed overflow pattern, a plain case for the unsigned ops
			run_op(div_op_e'(k), most_neg, '1, 1'b0);
		end

		// A hazard holds off the request and div_out keeps its value
		@(posedge CLK);
		#1;
		div_valid   = 1'b1;
		load_hazard = 1'b1;
		div_op      = DIVU;
		op_a        = XLEN'(1000);
		op_b        = XLEN'(3);
		repeat (4) begin
			@(negedge CLK);
			check_running(1'b0, div_running);
			check_out(last_expected, div_out);
		end
		run_op(DIVU, XLEN'(1000), XLEN'(3), 1'b0);

		// Operand inputs change while the divide runs
		for (int k = 0; k < 8; k++) begin
			run_op(div_op_e'(k % 4), rand_word(), rand_word(), 1'b1);
		end

		// Back-to-back random operations
		for (int n = 0; n < 300; n++) begin
			r = lcg_next();
			a = rand_word();
			b = rand_word();
			if (r[27:24] == 0) begin
				b = '0;
			end else if (r[23:21] == 0) begin
				// Small divisors give long quotients
				b = b >> r[20:16];
			end else if (r[12:9] == 0) begin
				a = most_neg;
				b = '1;
			end
			run_op(div_op_e'(r[31:30]), a, b, r[15]);
		end

		// One more edge so the compare process has seen the last result
		@(posedge CLK);
		#1;
		if ((checked == issued) && (expect_q.size() == 0)) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			report_failure($sformatf("Only %0d of %0d results were compared", checked, issued));
		end
	end

endmodule

`default_nettype wire

/* list.f */
design/div_pkg.sv
design/div_ctrl_fsm.sv
design/div_step_counter.sv
design/div_datapath.sv
design/div_result_sel.sv
design/divider_unit.sv
tb/tb_divider_unit.sv

/* Makefile */
# Verilator build and run for the divider unit

LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -f list.f --top-module tb_divider_unit \
		--Mdir obj_dir -o sim_divider
	./obj_dir/sim_divider | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	verilator --lint-only -Wall -f list.f --top-module divider_unit

clean:
	rm -rf obj_dir $(LOG)
